// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_rv32_core
FILELIST  := rv32_core.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: rv32_core.f
rv32_core_pkg.sv
rv32_regfile.sv
rv32_fetch.sv
rv32_decode.sv
rv32_execute.sv
rv32_core.sv
tb_rv32_core.sv

// File: rv32_core.sv
module rv32_core import rv32_core_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  output word_t      instr_addr,
  input  word_t      instr_rdata,
  output word_t      data_addr,
  output word_t      data_wdata,
  output logic [3:0] data_we,
  output logic       data_re,
  input  word_t      data_rdata
);

  fd_t       fd;
  de_t       de;
  wb_t       wb;
  redirect_t redirect;
  logic      stall;
  logic      load_in_ex;

  rv32_fetch u_fetch (
    .clk         (clk),
    .rst         (rst),
    .stall       (stall),
    .redirect    (redirect),
    .instr_addr  (instr_addr),
    .instr_rdata (instr_rdata),
    .fd          (fd)
  );

  rv32_decode u_decode (
    .clk        (clk),
    .rst        (rst),
    .fd         (fd),
    .wb         (wb),
    .load_in_ex (load_in_ex),
    .redirect   (redirect),
    .stall      (stall),
    .de         (de)
  );

  // Memory access and register write happen here
  rv32_execute u_execute (
    .de         (de),
    .redirect   (redirect),
    .wb         (wb),
    .load_in_ex (load_in_ex),
    .data_addr  (data_addr),
    .data_wdata (data_wdata),
    .data_we    (data_we),
    .data_re    (data_re),
    .data_rdata (data_rdata)
  );

endmodule

// File: rv32_core_pkg.sv
package rv32_core_pkg;

  localparam int xlen = 32;

  typedef logic [4:0]      reg_addr_t;
  typedef logic [xlen-1:0] word_t;

  // addi x0, x0, 0 marks an empty stage
  localparam word_t nop_word = 32'h00000013;

  // Major opcodes
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;

  // Branch forms
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // Load forms
  localparam logic [2:0] f3_lb  = 3'b000;
  localparam logic [2:0] f3_lh  = 3'b001;
  localparam logic [2:0] f3_lw  = 3'b010;
  localparam logic [2:0] f3_lbu = 3'b100;
  localparam logic [2:0] f3_lhu = 3'b101;

  // Store forms
  localparam logic [2:0] f3_sb = 3'b000;
  localparam logic [2:0] f3_sh = 3'b001;
  localparam logic [2:0] f3_sw = 3'b010;

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // One instruction word, six ways to read it
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } instr_u;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } alu_op_e;

  typedef enum logic [1:0] {op1_rs1, op1_pc, op1_zero} op1_sel_e;

  typedef enum logic [1:0] {wb_alu, wb_mem, wb_pc4} wb_sel_e;

  typedef struct packed {
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    logic       branch;
    logic       jump;
    logic       is_jalr;
    logic       op2_imm;
    alu_op_e    alu_op;
    op1_sel_e   op1_sel;
    wb_sel_e    wb_sel;
    logic [2:0] funct3;
  } ctrl_t;

  typedef struct packed {
    word_t pc;
    word_t instr;
  } fd_t;

  typedef struct packed {
    word_t     pc;
    ctrl_t     ctrl;
    reg_addr_t rd;
    word_t     rs1_val;
    word_t     rs2_val;
    word_t     imm;
    logic      valid;
  } de_t;

  typedef struct packed {
    logic      we;
    reg_addr_t rd;
    word_t     data;
  } wb_t;

  typedef struct packed {
    logic  taken;
    word_t target;
  } redirect_t;

endpackage

// File: rv32_decode.sv
module rv32_decode import rv32_core_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  fd_t       fd,
  input  wb_t       wb,
  input  logic      load_in_ex,
  input  redirect_t redirect,
  output logic      stall,
  output de_t       de
);

  instr_u    ins;
  ctrl_t     ctrl;
  word_t     imm;
  logic      valid;
  logic      use_rs1;
  logic      use_rs2;
  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  word_t     imm_i;
  word_t     imm_s;
  word_t     imm_b;
  word_t     imm_u;
  word_t     imm_j;
  word_t     rf_rd1;
  word_t     rf_rd2;
  logic      fwd_rs1;
  logic      fwd_rs2;
  word_t     rs1_val;
  word_t     rs2_val;

  function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? alu_sub : alu_add;
      3'b001:  op = alu_sll;
      3'b010:  op = alu_slt;
      3'b011:  op = alu_sltu;
      3'b100:  op = alu_xor;
      3'b101:  op = alt ? alu_sra : alu_srl;
      3'b110:  op = alu_or;
      default: op = alu_and;
    endcase
    return op;
  endfunction

  assign ins = fd.instr;
  assign rs1 = ins.r_fmt.rs1;
  assign rs2 = ins.r_fmt.rs2;
  assign rd  = ins.r_fmt.rd;

  // Sign-extended immediates per format
  assign imm_i = {{20{ins.i_fmt.imm[11]}}, ins.i_fmt.imm};
  assign imm_s = {{20{ins.s_fmt.imm_hi[6]}}, ins.s_fmt.imm_hi, ins.s_fmt.imm_lo};
  assign imm_b = {{19{ins.b_fmt.imm12}}, ins.b_fmt.imm12, ins.b_fmt.imm11,
                  ins.b_fmt.imm10_5, ins.b_fmt.imm4_1, 1'b0};
  assign imm_u = {ins.u_fmt.imm, 12'h000};
  assign imm_j = {{11{ins.j_fmt.imm20}}, ins.j_fmt.imm20, ins.j_fmt.imm19_12,
                  ins.j_fmt.imm11, ins.j_fmt.imm10_1, 1'b0};

  always_comb begin
    ctrl         = '0;
    ctrl.alu_op  = alu_add;
    ctrl.op1_sel = op1_rs1;
    ctrl.wb_sel  = wb_alu;
    ctrl.funct3  = ins.r_fmt.funct3;
    imm          = imm_i;
    valid        = 1'b1;
    use_rs1      = 1'b0;
    use_rs2      = 1'b0;
    case (ins.r_fmt.opcode)
      op_lui, op_auipc: begin
        ctrl.reg_write = 1'b1;
        ctrl.op2_imm   = 1'b1;
        ctrl.op1_sel   = (ins.r_fmt.opcode == op_lui) ? op1_zero : op1_pc;
        imm            = imm_u;
      end
      op_jal, op_jalr: begin
        ctrl.reg_write = 1'b1;
        ctrl.jump      = 1'b1;
        ctrl.is_jalr   = (ins.r_fmt.opcode == op_jalr);
        ctrl.wb_sel    = wb_pc4;
        imm            = ctrl.is_jalr ? imm_i : imm_j;
        use_rs1        = ctrl.is_jalr;
      end
      op_branch: begin
        ctrl.branch = 1'b1;
        imm         = imm_b;
        use_rs1     = 1'b1;
        use_rs2     = 1'b1;
      end
      op_load: begin
        ctrl.reg_write = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.op2_imm   = 1'b1;
        ctrl.wb_sel    = wb_mem;
        use_rs1        = 1'b1;
      end
      op_store: begin
        ctrl.mem_write = 1'b1;
        ctrl.op2_imm   = 1'b1;
        imm            = imm_s;
        use_rs1        = 1'b1;
        use_rs2        = 1'b1;
      end
      op_imm: begin
        ctrl.reg_write = 1'b1;
        ctrl.op2_imm   = 1'b1;
        // ADDI never subtracts, so only SRAI looks at funct7
        ctrl.alu_op    = alu_decode(ins.r_fmt.funct3,
                                    (ins.r_fmt.funct3 == 3'b101) && ins.r_fmt.funct7[5]);
        use_rs1        = 1'b1;
      end
      op_reg: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = alu_decode(ins.r_fmt.funct3, ins.r_fmt.funct7[5]);
        use_rs1        = 1'b1;
        use_rs2        = 1'b1;
      end
      default: valid = 1'b0;
    endcase
  end

  rv32_regfile u_regfile (
    .clk (clk),
    .rst (rst),
    .ra1 (rs1),
    .ra2 (rs2),
    .rd1 (rf_rd1),
    .rd2 (rf_rd2),
    .wb  (wb)
  );

  // Execute result overrides the stale register value
  assign fwd_rs1 = wb.we && (wb.rd != 5'd0) && (wb.rd == rs1);
  assign fwd_rs2 = wb.we && (wb.rd != 5'd0) && (wb.rd == rs2);
  assign rs1_val = fwd_rs1 ? wb.data : rf_rd1;
  assign rs2_val = fwd_rs2 ? wb.data : rf_rd2;

  // Load-use hazard holds decode for one cycle until the load reaches the register file
  assign stall = load_in_ex && (wb.rd != 5'd0) &&
                 ((use_rs1 && (wb.rd == rs1)) || (use_rs2 && (wb.rd == rs2)));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      de <= '0;
    end else if (stall || redirect.taken) begin
      de.ctrl  <= '0;
      de.valid <= 1'b0;
    end else begin
      de.pc      <= fd.pc;
      de.ctrl    <= ctrl;
      de.rd      <= rd;
      de.rs1_val <= rs1_val;
      de.rs2_val <= rs2_val;
      de.imm     <= imm;
      de.valid   <= valid;
    end
  end

  // The bubble behind a load clears the hazard
  a_stall_once : assert property (
    @(posedge clk) disable iff (rst)
    stall |=> !stall
  ) else $error("load-use stall lasted more than one cycle");

endmodule

// File: rv32_execute.sv
module rv32_execute import rv32_core_pkg::*; (
  input  de_t        de,
  output redirect_t  redirect,
  output wb_t        wb,
  output logic       load_in_ex,
  output word_t      data_addr,
  output word_t      data_wdata,
  output logic [3:0] data_we,
  output logic       data_re,
  input  word_t      data_rdata
);

  word_t       op1;
  word_t       op2;
  word_t       alu_res;
  logic        cmp_taken;
  word_t       jalr_sum;
  logic [3:0]  st_be;
  word_t       st_data;
  logic [7:0]  ld_byte;
  logic [15:0] ld_half;
  word_t       ld_data;

  always_comb begin
    case (de.ctrl.op1_sel)
      op1_pc:   op1 = de.pc;
      op1_zero: op1 = '0;
      default:  op1 = de.rs1_val;
    endcase
  end

  assign op2 = de.ctrl.op2_imm ? de.imm : de.rs2_val;

  always_comb begin
    case (de.ctrl.alu_op)
      alu_sub:  alu_res = op1 - op2;
      alu_sll:  alu_res = op1 << op2[4:0];
      alu_slt:  alu_res = {31'b0, $signed(op1) < $signed(op2)};
      alu_sltu: alu_res = {31'b0, op1 < op2};
      alu_xor:  alu_res = op1 ^ op2;
      alu_srl:  alu_res = op1 >> op2[4:0];
      alu_sra:  alu_res = word_t'($signed(op1) >>> op2[4:0]);
      alu_or:   alu_res = op1 | op2;
      alu_and:  alu_res = op1 & op2;
      default:  alu_res = op1 + op2;
    endcase
  end

  // Branch compare on the raw register values
  always_comb begin
    case (de.ctrl.funct3)
      f3_beq:  cmp_taken = (de.rs1_val == de.rs2_val);
      f3_bne:  cmp_taken = (de.rs1_val != de.rs2_val);
      f3_blt:  cmp_taken = ($signed(de.rs1_val) < $signed(de.rs2_val));
      f3_bge:  cmp_taken = ($signed(de.rs1_val) >= $signed(de.rs2_val));
      f3_bltu: cmp_taken = (de.rs1_val < de.rs2_val);
      f3_bgeu: cmp_taken = (de.rs1_val >= de.rs2_val);
      default: cmp_taken = 1'b0;
    endcase
  end

  assign jalr_sum        = de.rs1_val + de.imm;
  assign redirect.taken  = de.valid && (de.ctrl.jump || (de.ctrl.branch && cmp_taken));
  assign redirect.target = de.ctrl.is_jalr ? {jalr_sum[31:1], 1'b0} : (de.pc + de.imm);

  // Store data is replicated in every lane and the enables pick the lane
  always_comb begin
    st_be   = 4'b1111;
    st_data = de.rs2_val;
    case (de.ctrl.funct3)
      f3_sb: begin
        st_be   = 4'b0001 << alu_res[1:0];
        st_data = {4{de.rs2_val[7:0]}};
      end
      f3_sh: begin
        st_be   = alu_res[1] ? 4'b1100 : 4'b0011;
        st_data = {2{de.rs2_val[15:0]}};
      end
      default: ;
    endcase
  end

  assign data_addr  = alu_res;
  assign data_wdata = st_data;
  assign data_we    = (de.valid && de.ctrl.mem_write) ? st_be : 4'b0000;
  assign data_re    = de.valid && de.ctrl.mem_read;
  assign load_in_ex = data_re;

  // Load lane pick and extension
  assign ld_byte = data_rdata[8*alu_res[1:0] +: 8];
  assign ld_half = data_rdata[16*alu_res[1] +: 16];

  always_comb begin
    case (de.ctrl.funct3)
      f3_lb:   ld_data = {{24{ld_byte[7]}}, ld_byte};
      f3_lbu:  ld_data = {24'h000000, ld_byte};
      f3_lh:   ld_data = {{16{ld_half[15]}}, ld_half};
      f3_lhu:  ld_data = {16'h0000, ld_half};
      default: ld_data = data_rdata;
    endcase
  end

  assign wb.we = de.valid && de.ctrl.reg_write;
  assign wb.rd = de.rd;

  always_comb begin
    case (de.ctrl.wb_sel)
      wb_mem:  wb.data = ld_data;
      wb_pc4:  wb.data = de.pc + 32'd4;
      default: wb.data = alu_res;
    endcase
  end

  // Decode never marks one instruction as both load and store
  always_comb begin
    a_mem_excl : assert final (!(data_re && (data_we != 4'b0000)))
      else $error("data_we and data_re active together");
  end

endmodule

// File: rv32_fetch.sv
module rv32_fetch import rv32_core_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      stall,
  input  redirect_t redirect,
  output word_t     instr_addr,
  input  word_t     instr_rdata,
  output fd_t       fd
);

  word_t pc;
  word_t pc_next;

  assign instr_addr = pc;

  // Redirect wins over stall, stall wins over sequence
  always_comb begin
    if (redirect.taken) begin
      pc_next = redirect.target;
    end else if (stall) begin
      pc_next = pc;
    end else begin
      pc_next = pc + 32'd4;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

  // Fetch/decode register
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fd.pc    <= '0;
      fd.instr <= nop_word;
    end else if (redirect.taken) begin
      // Wrong-path word is dropped
      fd.instr <= nop_word;
    end else if (!stall) begin
      fd.pc    <= pc;
      fd.instr <= instr_rdata;
    end
  end

  // A load stall and a taken redirect come from different instructions
  a_no_stall_redirect : assert property (
    @(posedge clk) disable iff (rst)
    !(stall && redirect.taken)
  ) else $error("stall and taken redirect in the same cycle");

endmodule

// File: rv32_regfile.sv
module rv32_regfile import rv32_core_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  reg_addr_t ra1,
  input  reg_addr_t ra2,
  output word_t     rd1,
  output word_t     rd2,
  input  wb_t       wb
);

  // x0 has no storage
  word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (wb.we && (wb.rd != 5'd0)) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // Combinational reads, with same-cycle writes forwarded in decode
  assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
  assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

  // The next read of a written register returns the new value and x0 stays zero
  a_write_read : assert property (
    @(posedge clk) disable iff (rst)
    wb.we |=> (ra1 != $past(wb.rd)) ||
              (rd1 == (($past(wb.rd) == 5'd0) ? 32'd0 : $past(wb.data)))
  ) else $error("register read after write returned a wrong value");

endmodule

// File: tb_rv32_core.sv
module tb_rv32_core import rv32_core_pkg::*;;

  localparam int prog_len      = 50;
  localparam int num_stores    = 19;
  localparam int store_timeout = 200;
  localparam int quiet_cycles  = 40;

  typedef struct packed {
    word_t      addr;
    logic [3:0] be;
    word_t      data;
  } store_t;

  logic       clk;
  logic       rst;
  word_t      instr_addr;
  word_t      instr_rdata;
  word_t      data_addr;
  word_t      data_wdata;
  logic [3:0] data_we;
  logic       data_re;
  word_t      data_rdata;

  word_t  imem [0:63];
  word_t  dmem [0:63];
  store_t expected [0:num_stores-1];

  rv32_core i_dut (
    .clk         (clk),
    .rst         (rst),
    .instr_addr  (instr_addr),
    .instr_rdata (instr_rdata),
    .data_addr   (data_addr),
    .data_wdata  (data_wdata),
    .data_we     (data_we),
    .data_re     (data_re),
    .data_rdata  (data_rdata)
  );

  // Small assembler for the six RV32I formats
  function automatic word_t r_word(input logic [6:0] f7, input logic [2:0] f3,
                                   input reg_addr_t rd, input reg_addr_t rs1,
                                   input reg_addr_t rs2);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic word_t i_word(input logic [6:0] op, input logic [2:0] f3,
                                   input reg_addr_t rd, input reg_addr_t rs1,
                                   input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t s_word(input logic [2:0] f3, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
  endfunction

  function automatic word_t b_word(input logic [2:0] f3, input reg_addr_t rs1,
                                   input reg_addr_t rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
  endfunction

  function automatic word_t u_word(input logic [6:0] op, input reg_addr_t rd,
                                   input logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  function automatic word_t j_word(input reg_addr_t rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
  endfunction

  function automatic word_t lane_mask(input logic [3:0] be);
    return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  endfunction

  // Past the end of the program the fetch sees bubbles
  function automatic word_t instr_at(input word_t addr);
    word_t w;
    if (addr < 32'(4 * prog_len)) begin
      w = imem[addr[7:2]];
    end else begin
      w = nop_word;
    end
    return w;
  endfunction

  task automatic load_program();
    int k;
    for (k = 0; k < 64; k++) begin
      imem[k] = nop_word;
    end
    // ALU chain with forwarding into a store base held in x10
    imem[0]  = u_word(op_lui, 5'd1, 20'h12345);
    imem[1]  = i_word(op_imm, 3'b000, 5'd1, 5'd1, 12'h678);
    imem[2]  = i_word(op_imm, 3'b000, 5'd10, 5'd0, 12'h080);
    imem[3]  = s_word(f3_sw, 5'd1, 5'd10, 12'd0);
    imem[4]  = u_word(op_auipc, 5'd2, 20'h00001);
    imem[5]  = r_word(7'h20, 3'b000, 5'd3, 5'd2, 5'd1);
    imem[6]  = s_word(f3_sw, 5'd3, 5'd10, 12'd4);
    imem[7]  = i_word(op_imm, 3'b101, 5'd4, 5'd3, 12'h404);
    imem[8]  = r_word(7'h00, 3'b100, 5'd5, 5'd4, 5'd1);
    imem[9]  = s_word(f3_sw, 5'd5, 5'd10, 12'd8);
    imem[10] = i_word(op_imm, 3'b010, 5'd6, 5'd3, 12'd0);
    imem[11] = i_word(op_imm, 3'b001, 5'd7, 5'd6, 12'd31);
    imem[12] = r_word(7'h00, 3'b101, 5'd7, 5'd7, 5'd6);
    imem[13] = s_word(f3_sw, 5'd7, 5'd10, 12'd12);
    // Load then immediate use
    imem[14] = i_word(op_imm, 3'b000, 5'd11, 5'd0, 12'h040);
    imem[15] = i_word(op_load, f3_lw, 5'd12, 5'd11, 12'd4);
    imem[16] = r_word(7'h00, 3'b000, 5'd13, 5'd12, 5'd1);
    imem[17] = s_word(f3_sw, 5'd13, 5'd10, 12'd16);
    // Sub-word loads
    imem[18] = i_word(op_load, f3_lb, 5'd14, 5'd11, 12'd0);
    imem[19] = s_word(f3_sw, 5'd14, 5'd10, 12'd20);
    imem[20] = i_word(op_load, f3_lbu, 5'd15, 5'd11, 12'd2);
    imem[21] = s_word(f3_sw, 5'd15, 5'd10, 12'd24);
    imem[22] = i_word(op_load, f3_lh, 5'd16, 5'd11, 12'd2);
    imem[23] = s_word(f3_sw, 5'd16, 5'd10, 12'd28);
    imem[24] = i_word(op_load, f3_lhu, 5'd17, 5'd11, 12'd0);
    imem[25] = s_word(f3_sw, 5'd17, 5'd10, 12'd32);
    // Byte and half stores at every offset
    imem[26] = s_word(f3_sb, 5'd1, 5'd10, 12'd36);
    imem[27] = s_word(f3_sb, 5'd1, 5'd10, 12'd37);
    imem[28] = s_word(f3_sb, 5'd1, 5'd10, 12'd38);
    imem[29] = s_word(f3_sb, 5'd1, 5'd10, 12'd39);
    imem[30] = s_word(f3_sh, 5'd1, 5'd10, 12'd40);
    imem[31] = s_word(f3_sh, 5'd1, 5'd10, 12'd42);
    // Branches around the stores at 33, 34 and 38, which must never show up
    imem[32] = b_word(f3_beq, 5'd1, 5'd1, 13'd12);
    imem[33] = s_word(f3_sw, 5'd1, 5'd10, 12'd44);
    imem[34] = s_word(f3_sw, 5'd1, 5'd10, 12'd48);
    imem[35] = b_word(f3_bne, 5'd1, 5'd1, 13'd12);
    imem[36] = s_word(f3_sw, 5'd6, 5'd10, 12'd52);
    imem[37] = b_word(f3_blt, 5'd3, 5'd1, 13'd8);
    imem[38] = s_word(f3_sw, 5'd1, 5'd10, 12'd56);
    imem[39] = b_word(f3_bltu, 5'd3, 5'd1, 13'd8);
    imem[40] = s_word(f3_sw, 5'd7, 5'd10, 12'd56);
    // Jumps with link and a JALR target whose bit 0 is set
    imem[41] = j_word(5'd18, 21'd12);
    imem[42] = s_word(f3_sw, 5'd1, 5'd10, 12'd60);
    imem[43] = s_word(f3_sw, 5'd1, 5'd10, 12'd60);
    imem[44] = s_word(f3_sw, 5'd18, 5'd10, 12'd60);
    imem[45] = i_word(op_imm, 3'b000, 5'd19, 5'd0, 12'd193);
    imem[46] = i_word(op_jalr, 3'b000, 5'd20, 5'd19, 12'd0);
    imem[47] = s_word(f3_sw, 5'd1, 5'd10, 12'd64);
    imem[48] = s_word(f3_sw, 5'd20, 5'd10, 12'd64);
    imem[49] = j_word(5'd0, 21'd0);
  endtask

  task automatic preload_data();
    int k;
    for (k = 0; k < 64; k++) begin
      dmem[k] = 32'hc0de0000 | 32'(k * 4);
    end
    dmem[16] = 32'h80f17e92;
    dmem[17] = 32'h00001f2e;
  endtask

  // Address, byte enables, data masked by the enables
  task automatic fill_expected();
    expected[0]  = '{32'h00000080, 4'hf, 32'h12345678};
    expected[1]  = '{32'h00000084, 4'hf, 32'hedcbb998};
    expected[2]  = '{32'h00000088, 4'hf, 32'hece8ede1};
    expected[3]  = '{32'h0000008c, 4'hf, 32'h40000000};
    expected[4]  = '{32'h00000090, 4'hf, 32'h123475a6};
    expected[5]  = '{32'h00000094, 4'hf, 32'hffffff92};
    expected[6]  = '{32'h00000098, 4'hf, 32'h000000f1};
    expected[7]  = '{32'h0000009c, 4'hf, 32'hffff80f1};
    expected[8]  = '{32'h000000a0, 4'hf, 32'h00007e92};
    expected[9]  = '{32'h000000a4, 4'h1, 32'h00000078};
    expected[10] = '{32'h000000a5, 4'h2, 32'h00007800};
    expected[11] = '{32'h000000a6, 4'h4, 32'h00780000};
    expected[12] = '{32'h000000a7, 4'h8, 32'h78000000};
    expected[13] = '{32'h000000a8, 4'h3, 32'h00005678};
    expected[14] = '{32'h000000aa, 4'hc, 32'h56780000};
    expected[15] = '{32'h000000b4, 4'hf, 32'h00000001};
    expected[16] = '{32'h000000b8, 4'hf, 32'h40000000};
    expected[17] = '{32'h000000bc, 4'hf, 32'h000000a8};
    expected[18] = '{32'h000000c0, 4'hf, 32'h000000bc};
  endtask

  task automatic check_equal(input string name, input word_t actual, input word_t exp_val);
    if (actual !== exp_val) begin
      $display("FAILED %s: got 0x%08h, expected 0x%08h", name, actual, exp_val);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic await_store(input int idx);
    int cycles;
    cycles = 0;
    @(posedge clk);
    #2;
    while (data_we == 4'b0000) begin
      if (cycles >= store_timeout) begin
        $display("Store %0d to address 0x%08h did not appear within %0d cycles",
                 idx, expected[idx].addr, store_timeout);
        $display("sim failed");
        $fatal(1);
      end else begin
        @(posedge clk);
        #2;
        cycles++;
      end
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Instruction and data memories that answer within the cycle
  initial begin
    instr_rdata = nop_word;
    data_rdata  = '0;
    load_program();
    preload_data();
    forever begin
      @(posedge clk);
      #1;
      if (data_we[0]) dmem[data_addr[7:2]][7:0]   = data_wdata[7:0];
      if (data_we[1]) dmem[data_addr[7:2]][15:8]  = data_wdata[15:8];
      if (data_we[2]) dmem[data_addr[7:2]][23:16] = data_wdata[23:16];
      if (data_we[3]) dmem[data_addr[7:2]][31:24] = data_wdata[31:24];
      instr_rdata = instr_at(instr_addr);
      // A read without data_re returns a marker word
      data_rdata  = data_re ? dmem[data_addr[7:2]] : 32'hdeadbeef;
    end
  end

  initial begin
    int i;
    int n;
    rst = 1'b1;
    fill_expected();
    repeat (8) @(posedge clk);
    #1;
    check_equal("instr_addr", instr_addr, 32'h0);
    check_equal("data_we", {28'h0, data_we}, 32'h0);
    check_equal("data_re", {31'h0, data_re}, 32'h0);
    rst = 1'b0;
    for (i = 0; i < num_stores; i++) begin
      await_store(i);
      check_equal("data_addr", data_addr, expected[i].addr);
      check_equal("data_we", {28'h0, data_we}, {28'h0, expected[i].be});
      check_equal("data_wdata", data_wdata & lane_mask(expected[i].be), expected[i].data);
      check_equal("data_re", {31'h0, data_re}, 32'h0);
    end
    // Self loop at the end must stay silent on the data bus
    for (n = 0; n < quiet_cycles; n++) begin
      @(posedge clk);
      #2;
      if (data_we != 4'b0000) begin
        $display("Unexpected extra store to address 0x%08h after the last expected one",
                 data_addr);
        $display("sim failed");
        $fatal(1);
      end
      check_equal("data_re", {31'h0, data_re}, 32'h0);
    end
    $display("sim passed");
    $finish;
  end

endmodule
